/* flist.f */
hdl/mma_pkg.sv
hdl/control_sequencer.sv
hdl/operand_buffer.sv
hdl/skew_feeder.sv
hdl/mac_array.sv
hdl/mma_top.sv
sim/mma_checker.sv
sim/mma_tb.sv

/* hdl/control_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module control_sequencer
    import mma_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             req_ready,
    input  logic             in_valid,
    input  logic             in_last,
    output logic             req_valid,
    output mat_sel_t         req_sel,
    output logic [31:0]      req_base,
    output logic [LEN_W-1:0] req_len,
    output logic             wr_c,
    output logic             wr_a,
    output logic             wr_b,
    output logic [IDX_W-1:0] wr_idx,
    output logic [IDX_W-1:0] rd_idx,
    output logic             feed_en,
    output logic             feed_step,
    output logic             preload_en,
    output logic             mac_en,
    output logic             drain_en,
    output logic             out_valid,
    output logic             out_last
);

    seq_state_t       state;
    logic [CNT_W-1:0] cnt;                      // Beat or phase counter

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            cnt       <= '0;
            req_valid <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= (state == DRAIN);      // Lines up with registered drain row
            out_last  <= (state == DRAIN) && (cnt == CNT_W'(DIM - 1));
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= LOAD_C;
                        cnt       <= '0;
                        req_valid <= 1'b1;
                    end
                end
                LOAD_C, LOAD_A, LOAD_B: begin
                    if (in_valid) begin
                        cnt <= cnt + 1'b1;
                        if (in_last) begin
                            cnt <= '0;
                            case (state)
                                LOAD_C:  state <= LOAD_A;
                                LOAD_A:  state <= LOAD_B;
                                default: state <= PRELOAD;
                            endcase
                            req_valid <= (state != LOAD_B); // Next burst request
                        end
                    end
                end
                PRELOAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DIM - 1)) begin
                        state <= COMPUTE;
                        cnt   <= '0;
                    end
                end
                COMPUTE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(COMPUTE_CYCLES - 1)) begin
                        state <= DRAIN;
                        cnt   <= '0;
                    end
                end
                default: begin                  // DRAIN
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DIM - 1)) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end
                end
            endcase
        end
    end

    // Request fields follow the load state, so they hold while req_valid waits
    always_comb begin
        case (state)
            LOAD_A: begin
                req_sel  = MAT_A;
                req_base = A_BASE;
            end
            LOAD_B: begin
                req_sel  = MAT_B;
                req_base = B_BASE;
            end
            default: begin
                req_sel  = MAT_C;
                req_base = C_BASE;
            end
        endcase
    end

    assign req_len = LEN_W'(BURST_LEN - 1);

    assign wr_c   = in_valid && (state == LOAD_C);
    assign wr_a   = in_valid && (state == LOAD_A);
    assign wr_b   = in_valid && (state == LOAD_B);
    assign wr_idx = cnt[IDX_W-1:0];
    assign rd_idx = cnt[IDX_W-1:0];             // Also the preload row

    assign feed_en    = (state == COMPUTE);
    assign feed_step  = (cnt < CNT_W'(DIM));    // New operand step this cycle
    assign preload_en = (state == PRELOAD);
    assign mac_en     = (state == COMPUTE);
    assign drain_en   = (state == DRAIN);

endmodule

`default_nettype wire

/* hdl/mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_array
    import mma_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             preload_en,
    input  logic [IDX_W-1:0] preload_row,
    input  acc_row_t         preload_data,
    input  logic             mac_en,
    input  op_vec_t          a_left,
    input  op_vec_t          b_top,
    input  logic             drain_en,
    output acc_row_t         out_data
);

    acc_t acc_q [DIM][DIM];
    op_t  a_q   [DIM][DIM];                     // Forwarded right
    op_t  b_q   [DIM][DIM];                     // Forwarded down

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col
            op_t  a_in;
            op_t  b_in;
            acc_t prod;
            acc_t acc_below;

            if (j == 0) begin : g_a_edge
                assign a_in = a_left[i];
            end else begin : g_a_fwd
                assign a_in = a_q[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_top[j];
            end else begin : g_b_fwd
                assign b_in = b_q[i-1][j];
            end

            if (i == DIM - 1) begin : g_last_row
                assign acc_below = '0;
            end else begin : g_inner_row
                assign acc_below = acc_q[i+1][j];
            end

            assign prod = a_in * b_in;          // Signed, wraps to 32 bits

            always_ff @(posedge clk) begin
                if (preload_en) begin
                    if (preload_row == IDX_W'(i)) begin
                        acc_q[i][j] <= preload_data[j];
                    end
                end else if (drain_en) begin
                    acc_q[i][j] <= acc_below;   // Shift rows up
                end else if (mac_en) begin
                    acc_q[i][j] <= acc_q[i][j] + prod;
                end
            end

            always_ff @(posedge clk) begin
                if (rst || preload_en) begin
                    a_q[i][j] <= '0;
                    b_q[i][j] <= '0;
                end else if (mac_en) begin
                    a_q[i][j] <= a_in;
                    b_q[i][j] <= b_in;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (drain_en) begin
            for (int j = 0; j < DIM; j++) begin
                out_data[j] <= acc_q[0][j];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mma_pkg.sv */
`default_nettype none

package mma_pkg;

    localparam int DIM    = 4;                  // Array edge
    localparam int OP_W   = 8;
    localparam int ACC_W  = 32;
    localparam int BEAT_W = DIM * ACC_W;        // One C row per beat
    localparam int IDX_W  = $clog2(DIM);
    localparam int LEN_W  = 6;

    localparam logic [31:0] C_BASE = 32'h0001_0000;
    localparam logic [31:0] A_BASE = 32'h0010_0000;
    localparam logic [31:0] B_BASE = 32'h0100_0000;

    localparam int BURST_LEN      = DIM;
    localparam int COMPUTE_CYCLES = 3 * DIM - 1; // Last operand reaches far corner
    localparam int CNT_W          = $clog2(COMPUTE_CYCLES);

    typedef logic signed [OP_W-1:0]  op_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef op_t  [DIM-1:0] op_vec_t;
    typedef acc_t [DIM-1:0] acc_row_t;

    typedef enum logic [1:0] {
        MAT_C,
        MAT_A,
        MAT_B
    } mat_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_C,
        LOAD_A,
        LOAD_B,
        PRELOAD,
        COMPUTE,
        DRAIN
    } seq_state_t;

endpackage

`default_nettype wire

/* hdl/mma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mma_top
    import mma_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              req_ready,
    input  logic              in_valid,
    input  logic [BEAT_W-1:0] in_data,
    input  logic              in_last,
    output logic              req_valid,
    output mat_sel_t          req_sel,
    output logic [31:0]       req_base,
    output logic [LEN_W-1:0]  req_len,
    output logic              out_valid,
    output acc_row_t          out_data,
    output logic              out_last
);

    logic             wr_c;
    logic             wr_a;
    logic             wr_b;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             feed_en;
    logic             feed_step;
    logic             feed_go;
    logic             preload_en;
    logic             mac_en;
    logic             drain_en;
    logic [IDX_W-1:0] step_idx;
    acc_row_t         c_row;
    op_vec_t          a_col;
    op_vec_t          b_row;
    op_vec_t          a_lane;
    op_vec_t          b_lane;
    op_vec_t          ab_beat;

    assign ab_beat = op_vec_t'(in_data[DIM*OP_W-1:0]); // A and B use the low lanes
    assign feed_go = feed_en & feed_step;

    control_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .req_ready  (req_ready),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .req_valid  (req_valid),
        .req_sel    (req_sel),
        .req_base   (req_base),
        .req_len    (req_len),
        .wr_c       (wr_c),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .wr_idx     (wr_idx),
        .rd_idx     (rd_idx),
        .feed_en    (feed_en),
        .feed_step  (feed_step),
        .preload_en (preload_en),
        .mac_en     (mac_en),
        .drain_en   (drain_en),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

    operand_buffer #(.payload_t(acc_row_t)) c_buf_i (
        .clk     (clk),
        .wr_en   (wr_c),
        .wr_idx  (wr_idx),
        .wr_data (acc_row_t'(in_data)),
        .rd_idx  (rd_idx),
        .rd_data (c_row)
    );

    operand_buffer #(.payload_t(op_vec_t)) a_buf_i (
        .clk     (clk),
        .wr_en   (wr_a),
        .wr_idx  (wr_idx),
        .wr_data (ab_beat),
        .rd_idx  (step_idx),
        .rd_data (a_col)
    );

    operand_buffer #(.payload_t(op_vec_t)) b_buf_i (
        .clk     (clk),
        .wr_en   (wr_b),
        .wr_idx  (wr_idx),
        .wr_data (ab_beat),
        .rd_idx  (step_idx),
        .rd_data (b_row)
    );

    skew_feeder feeder_i (
        .clk        (clk),
        .rst        (rst),
        .feed_en    (feed_go),
        .a_col      (a_col),
        .b_row      (b_row),
        .step_idx   (step_idx),
        .a_lane     (a_lane),
        .b_lane     (b_lane),
        .lane_valid ()
    );

    mac_array array_i (
        .clk          (clk),
        .rst          (rst),
        .preload_en   (preload_en),
        .preload_row  (rd_idx),
        .preload_data (c_row),
        .mac_en       (mac_en),
        .a_left       (a_lane),
        .b_top        (b_lane),
        .drain_en     (drain_en),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

/* hdl/operand_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_buffer
    import mma_pkg::*;
#(
    parameter type payload_t = op_vec_t
) (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [IDX_W-1:0] wr_idx,
    input  payload_t         wr_data,
    input  logic [IDX_W-1:0] rd_idx,
    output payload_t         rd_data
);

    payload_t mem [DIM];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];               // Async read

endmodule

`default_nettype wire

/* hdl/skew_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module skew_feeder
    import mma_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             feed_en,
    input  op_vec_t          a_col,
    input  op_vec_t          b_row,
    output logic [IDX_W-1:0] step_idx,
    output op_vec_t          a_lane,
    output op_vec_t          b_lane,
    output logic [DIM-1:0]   lane_valid
);

    op_vec_t a_stage [DIM];
    op_vec_t b_stage [DIM];

    always_ff @(posedge clk) begin
        if (rst) begin
            step_idx   <= '0;
            lane_valid <= '0;
        end else begin
            step_idx   <= feed_en ? step_idx + 1'b1 : '0;
            lane_valid <= {lane_valid[DIM-2:0], feed_en}; // Bit i is stage i
        end
    end

    // Idle cycles push zeros, so the tail of the wavefront adds nothing
    always_ff @(posedge clk) begin
        a_stage[0] <= feed_en ? a_col : '0;
        b_stage[0] <= feed_en ? b_row : '0;
        for (int s = 1; s < DIM; s++) begin
            a_stage[s] <= a_stage[s-1];
            b_stage[s] <= b_stage[s-1];
        end
    end

    for (genvar i = 0; i < DIM; i++) begin : g_lane
        assign a_lane[i] = a_stage[i][i];       // i+1 cycles late
        assign b_lane[i] = b_stage[i][i];
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the matrix-multiply testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f flist.f --top-module mma_tb -o mma_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mma_sim)
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
exit 1

/* sim/mma_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mma_checker
    import mma_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             req_valid,
    input logic             req_ready,
    input mat_sel_t         req_sel,
    input logic [31:0]      req_base,
    input logic [LEN_W-1:0] req_len,
    input logic             out_valid,
    input logic             out_last
);

    int hold_fails = 0;
    int drop_fails = 0;
    int last_fails = 0;
    int excl_fails = 0;
    int fail_count;

    assign fail_count = hold_fails + drop_fails + last_fails + excl_fails;

    // Pending request keeps its fields
    req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_sel)
                                    && $stable(req_base) && $stable(req_len))
        else begin
            hold_fails++;
            $error("request withdrawn or changed before req_ready");
        end

    req_drop: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> !req_valid)
        else begin
            drop_fails++;
            $error("req_valid still high after the handshake");
        end

    last_in_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else begin
            last_fails++;
            $error("out_last without out_valid");
        end

    // No new request while results stream out
    req_vs_out: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !req_valid)
        else begin
            excl_fails++;
            $error("req_valid high during result output");
        end

endmodule

`default_nettype wire

/* sim/mma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mma_tb
    import mma_pkg::*;
();

    localparam int TIMEOUT  = 200;              // Cycles allowed for any single wait
    localparam int NUM_JOBS = 5;

    logic              clk = 1'b0;
    logic              rst;
    logic              start;
    logic              req_ready;
    logic              in_valid;
    logic [BEAT_W-1:0] in_data;
    logic              in_last;
    logic              req_valid;
    mat_sel_t          req_sel;
    logic [31:0]       req_base;
    logic [LEN_W-1:0]  req_len;
    logic              out_valid;
    acc_row_t          out_data;
    logic              out_last;

    int seed           = 32'h1a9a_494a;
    int value_errors   = 0;
    int timeout_errors = 0;
    int protocol_fails = 0;
    bit stalled        = 1'b0;

    int a_mat   [DIM][DIM];
    int b_mat   [DIM][DIM];
    int c_mat   [DIM][DIM];
    int exp_mat [DIM][DIM];

    mat_sel_t    order_sel  [3] = '{MAT_C, MAT_A, MAT_B};
    logic [31:0] order_base [3] = '{C_BASE, A_BASE, B_BASE};

    always #4 clk = ~clk;

    mma_top dut_i (.*);

    bind mma_top mma_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_sel   (req_sel),
        .req_base  (req_base),
        .req_len   (req_len),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    task automatic flag_mismatch(input string what, input int got, input int expected);
        value_errors++;
        $display("error %0t: %s got %0d expected %0d", $time, what, got, expected);
    endtask

    task automatic prepare_job(input int job);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                a_mat[i][j] = int'(byte'($random(seed)));
                b_mat[i][j] = int'(byte'($random(seed)));
                c_mat[i][j] = $random(seed);
                if (job == 1) begin             // Largest signed product, C near the top
                    a_mat[i][j] = -128;
                    b_mat[i][j] = -128;
                    c_mat[i][j] = int'(32'h7fff_ff00) + i * DIM + j;
                end else if (job == 3) begin
                    c_mat[i][j] = 0;
                end
            end
        end
    endtask

    // Reference result C + A*B in 32-bit wrapping arithmetic
    task automatic compute_expected();
        int acc;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                acc = c_mat[i][j];
                for (int k = 0; k < DIM; k++) begin
                    acc = acc + a_mat[i][k] * b_mat[k][j];
                end
                exp_mat[i][j] = acc;
            end
        end
    endtask

    function automatic logic [BEAT_W-1:0] pack_beat(input mat_sel_t sel, input int k);
        logic [BEAT_W-1:0] beat;
        beat = '0;
        for (int n = 0; n < DIM; n++) begin
            case (sel)
                MAT_C:   beat[ACC_W*n +: ACC_W] = c_mat[k][n];  // Row k of C
                MAT_A:   beat[OP_W*n +: OP_W] = a_mat[n][k][OP_W-1:0]; // Column k
                default: beat[OP_W*n +: OP_W] = b_mat[k][n][OP_W-1:0];
            endcase
        end
        return beat;
    endfunction

    task automatic send_burst(input mat_sel_t sel, input bit gaps);
        int gap;
        for (int k = 0; k < BURST_LEN; k++) begin
            gap = gaps ? ($random(seed) & 3) : 0;
            repeat (gap) @(negedge clk);
            in_valid = 1'b1;
            in_data  = pack_beat(sel, k);
            in_last  = (k == BURST_LEN - 1);
            @(negedge clk);
            in_valid = 1'b0;
            in_last  = 1'b0;
            in_data  = '0;
        end
    endtask

    task automatic serve_request(input int job, input int m, input bit gaps);
        int n;
        int delay;
        mat_sel_t sel;
        n = 0;
        while (!req_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!req_valid) begin
            timeout_errors++;
            stalled = 1'b1;
            $display("timeout: job %0d never issued request number %0d", job, m);
            return;
        end
        assert (req_sel == order_sel[m])
            else flag_mismatch("req_sel", int'(req_sel), int'(order_sel[m]));
        assert (req_base == order_base[m])
            else flag_mismatch("req_base", int'(req_base), int'(order_base[m]));
        assert (req_len == LEN_W'(BURST_LEN - 1))
            else flag_mismatch("req_len", int'(req_len), BURST_LEN - 1);
        delay = gaps ? ($random(seed) & 3) : 0;
        repeat (delay) @(negedge clk);
        sel       = req_sel;                    // Memory answers what was asked
        req_ready = 1'b1;
        @(negedge clk);
        req_ready = 1'b0;
        send_burst(sel, gaps);
    endtask

    task automatic collect_results(input int job);
        int n;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            timeout_errors++;
            stalled = 1'b1;
            $display("timeout: job %0d produced no result rows", job);
            return;
        end
        for (int r = 0; r < DIM; r++) begin
            if (r > 0) begin
                @(negedge clk);
            end
            assert (out_valid)
                else flag_mismatch($sformatf("job %0d row %0d out_valid", job, r), 0, 1);
            assert (out_last == (r == DIM - 1))
                else flag_mismatch($sformatf("job %0d row %0d out_last", job, r),
                                   int'(out_last), int'(r == DIM - 1));
            for (int j = 0; j < DIM; j++) begin
                assert (out_data[j] == exp_mat[r][j])
                    else flag_mismatch($sformatf("job %0d C[%0d][%0d]", job, r, j),
                                       out_data[j], exp_mat[r][j]);
            end
        end
        @(negedge clk);
        assert (!out_valid)
            else flag_mismatch($sformatf("job %0d extra out_valid", job), 1, 0);
    endtask

    task automatic run_job(input int job, input bit gaps);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int m = 0; m < 3; m++) begin
            serve_request(job, m, gaps);
            if (stalled) begin
                return;
            end
        end
        collect_results(job);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        req_ready = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!req_valid) else flag_mismatch("req_valid after reset", 1, 0);
        assert (!out_valid) else flag_mismatch("out_valid after reset", 1, 0);
        assert (!out_last) else flag_mismatch("out_last after reset", 1, 0);

        // Job 0 runs without stalls, the rest with random ready delays and gaps
        for (int job = 0; job < NUM_JOBS; job++) begin
            if (!stalled) begin
                prepare_job(job);
                compute_expected();
                run_job(job, job != 0);
            end
        end

        repeat (4) @(negedge clk);
        protocol_fails = dut_i.checker_i.fail_count;
        $display("errors: value %0d, timeout %0d, protocol %0d",
                 value_errors, timeout_errors, protocol_fails);
        if (value_errors + timeout_errors + protocol_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
